//--- verilog/rx_mac_consts.svh
`ifndef RX_MAC_CONSTS_SVH
`define RX_MAC_CONSTS_SVH

// Byte lane width of the PHY side and the output stream
`define RX_DATA_WIDTH 8

// Frame delimiters
`define ETH_PREAMBLE 8'h55   // Repeated before the SFD
`define ETH_SFD      8'hD5   // Start frame delimiter

// CRC-32 start state and good-frame residue
`define CRC_INIT    32'hFFFF_FFFF
`define CRC_RESIDUE 32'hC704_DD7B   // MSB-first form of the residue

// Shortest legal frame, destination address through FCS
`define ETH_MIN_FRAME 64

// Entry queue depth, power of two
`define RX_QUEUE_DEPTH 32

`endif

//--- verilog/eth_frame_pkg.sv
package eth_frame_pkg;

    // Frame synchronizer FSM states
    typedef enum logic [1:0] {
        sync_hunt,      // Idle, waiting for a preamble byte
        sync_preamble,  // In preamble, looking for the SFD
        sync_frame      // Forwarding frame bytes until dv falls
    } sync_state_t;

endpackage

//--- verilog/rx_queue_pkg.sv
`include "rx_mac_consts.svh"

package rx_queue_pkg;

    // Per-frame error summary, first field is the MSB
    typedef struct packed {
        logic       crc_bad;    // Residue check failed
        logic       phy_err;    // rx_er seen on some byte
        logic       runt;       // Shorter than the minimum frame
        logic       overflow;   // Bytes dropped on a full queue
        logic [3:0] reserved;   // Always zero
    } frame_status_t;

    // One queue word, a data byte or a status summary
    typedef union packed {
        logic [`RX_DATA_WIDTH-1:0] data;
        frame_status_t             status;
    } queue_word_u;

    // Queue entry, kind selects the view of word
    typedef struct packed {
        logic        kind;   // 1 = status, 0 = data
        queue_word_u word;
    } queue_entry_t;

endpackage

//--- verilog/rx_frame_sync.sv
`timescale 1ns/1ps
`include "rx_mac_consts.svh"

module rx_frame_sync (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [`RX_DATA_WIDTH-1:0] rx_data,
    input  logic                      rx_dv,
    input  logic                      rx_er,
    output logic                      byte_valid,
    output logic [`RX_DATA_WIDTH-1:0] byte_data,
    output logic                      byte_err,
    output logic                      frame_start,
    output logic                      frame_end
);

    logic [`RX_DATA_WIDTH-1:0]   rx_data_q;    // PHY input stage
    logic                        rx_dv_q;
    logic                        rx_er_q;
    logic                        first_byte;   // Next forwarded byte opens the frame
    eth_frame_pkg::sync_state_t  state;

    always_ff @(posedge clk) begin
        rx_data_q <= rx_data;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rx_dv_q <= 1'b0;
            rx_er_q <= 1'b0;
        end else begin
            rx_dv_q <= rx_dv;
            rx_er_q <= rx_er;
        end
    end

    // Preamble/SFD hunt and frame forwarding
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state       <= eth_frame_pkg::sync_hunt;
            first_byte  <= 1'b0;
            byte_valid  <= 1'b0;
            byte_err    <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;   // Single-cycle pulses by default
            byte_err    <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            case (state)
                eth_frame_pkg::sync_hunt: begin
                    if (rx_dv_q && rx_data_q == `ETH_PREAMBLE)
                        state <= eth_frame_pkg::sync_preamble;
                end
                eth_frame_pkg::sync_preamble: begin
                    if (!rx_dv_q) begin
                        state <= eth_frame_pkg::sync_hunt;   // Burst ended without SFD
                    end else if (rx_data_q == `ETH_SFD) begin
                        state      <= eth_frame_pkg::sync_frame;
                        first_byte <= 1'b1;
                    end else if (rx_data_q != `ETH_PREAMBLE) begin
                        state <= eth_frame_pkg::sync_hunt;   // Garbage inside preamble
                    end
                end
                eth_frame_pkg::sync_frame: begin
                    if (rx_dv_q) begin
                        byte_valid  <= 1'b1;
                        byte_err    <= rx_er_q;
                        frame_start <= first_byte;
                        first_byte  <= 1'b0;
                    end else begin
                        frame_end <= 1'b1;   // No byte with this pulse
                        state     <= eth_frame_pkg::sync_hunt;
                    end
                end
                default: state <= eth_frame_pkg::sync_hunt;
            endcase
        end
    end

    // Forwarded byte, qualified by byte_valid
    always_ff @(posedge clk) begin
        if (state == eth_frame_pkg::sync_frame && rx_dv_q)
            byte_data <= rx_data_q;
    end

endmodule

//--- verilog/crc32_byte.sv
`timescale 1ns/1ps
`include "rx_mac_consts.svh"

module crc32_byte (
    input  logic [31:0]               crc_in,
    input  logic [`RX_DATA_WIDTH-1:0] data_in,
    output logic [31:0]               crc_out
);

    logic [31:0] crc_work;   // State while bits are folded in

    // Reflected CRC-32, LSB of the byte first
    always_comb begin
        crc_work = crc_in;
        for (int i = 0; i < `RX_DATA_WIDTH; i++) begin
            if (crc_work[0] ^ data_in[i])
                crc_work = (crc_work >> 1) ^ 32'hEDB8_8320;   // Reversed 04C11DB7
            else
                crc_work = crc_work >> 1;
        end
    end

    // No final inversion, the raw state is compared against the residue
    assign crc_out = crc_work;

endmodule

//--- verilog/rx_fcs_check.sv
`timescale 1ns/1ps
`include "rx_mac_consts.svh"

module rx_fcs_check (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       byte_valid,
    input  logic [`RX_DATA_WIDTH-1:0]  byte_data,
    input  logic                       byte_err,
    input  logic                       frame_start,
    input  logic                       frame_end,
    input  logic                       almost_full,
    output logic                       wr_en,
    output rx_queue_pkg::queue_entry_t wr_entry
);

    logic [31:0]                           crc_state;
    logic [31:0]                           crc_seed;
    logic [31:0]                           crc_next;
    logic [31:0]                           crc_msb;     // State in MSB-first order
    logic [`RX_DATA_WIDTH-1:0]             dly [4];     // FCS hold-back line, dly[3] oldest
    logic [2:0]                            dly_fill;
    logic [$clog2(`ETH_MIN_FRAME + 1)-1:0] byte_cnt;    // Saturates at the minimum
    logic                                  phy_err;
    logic                                  overflow;
    logic                                  write_due;
    rx_queue_pkg::frame_status_t           status;

    assign crc_seed = frame_start ? `CRC_INIT : crc_state;   // Fresh CRC per frame

    crc32_byte crc32_byte_i (
        .crc_in  (crc_seed),
        .data_in (byte_data),
        .crc_out (crc_next)
    );

    assign crc_msb   = {<<{crc_state}};
    // Oldest byte leaves once four younger ones are behind it
    assign write_due = byte_valid && !frame_start && (dly_fill == 3'd4);

    always_comb begin
        status          = '0;
        status.crc_bad  = (crc_msb != `CRC_RESIDUE);
        status.phy_err  = phy_err;
        status.runt     = (byte_cnt < `ETH_MIN_FRAME);
        status.overflow = overflow;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_en    <= 1'b0;
            dly_fill <= '0;
            byte_cnt <= '0;
            phy_err  <= 1'b0;
            overflow <= 1'b0;
        end else begin
            // Status always writes, data only while room and no earlier drop
            wr_en <= frame_end || (write_due && !almost_full && !overflow);
            if (byte_valid) begin
                if (frame_start) begin
                    dly_fill <= 3'd1;
                    byte_cnt <= 1'b1;
                    phy_err  <= byte_err;
                    overflow <= 1'b0;
                end else begin
                    if (dly_fill != 3'd4)
                        dly_fill <= dly_fill + 1'b1;
                    if (byte_cnt < `ETH_MIN_FRAME)
                        byte_cnt <= byte_cnt + 1'b1;
                    phy_err <= phy_err | byte_err;
                    if (write_due && almost_full)
                        overflow <= 1'b1;   // Rest of this frame is dropped
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            crc_state <= crc_next;
            dly[0]    <= byte_data;
            dly[1]    <= dly[0];
            dly[2]    <= dly[1];
            dly[3]    <= dly[2];
        end
        if (frame_end) begin
            wr_entry.kind        <= 1'b1;
            wr_entry.word.status <= status;
        end else if (write_due) begin
            wr_entry.kind      <= 1'b0;
            wr_entry.word.data <= dly[3];
        end
    end

endmodule

//--- verilog/rx_entry_queue.sv
`timescale 1ns/1ps
`include "rx_mac_consts.svh"

module rx_entry_queue #(
    parameter int DEPTH = `RX_QUEUE_DEPTH
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       wr_en,
    input  rx_queue_pkg::queue_entry_t wr_entry,
    input  logic                       rd_en,
    output rx_queue_pkg::queue_entry_t rd_entry,
    output logic                       empty,
    output logic                       almost_full
);

    rx_queue_pkg::queue_entry_t   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;     // Wraps, DEPTH is a power of two
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH + 1)-1:0] count;      // Occupied slots
    logic                         do_wr;
    logic                         do_rd;

    assign do_wr = wr_en && (count != DEPTH);
    assign do_rd = rd_en && !empty;

    assign empty    = (count == 0);
    assign rd_entry = mem[rd_ptr];   // Show-ahead head
    // Fewer than two slots free once the write in progress lands,
    // so a full stall keeps DEPTH-1 data entries and room for the status
    assign almost_full = (count + wr_en) >= (DEPTH - 1);

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_entry;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

endmodule

//--- verilog/rx_stream_out.sv
`timescale 1ns/1ps
`include "rx_mac_consts.svh"

module rx_stream_out (
    input  logic                       clk,
    input  logic                       reset_n,
    input  rx_queue_pkg::queue_entry_t rd_entry,
    input  logic                       empty,
    output logic                       rd_en,
    output logic [`RX_DATA_WIDTH-1:0]  m_rx_axis_tdata,
    output logic                       m_rx_axis_tvalid,
    output logic                       m_rx_axis_tlast,
    output logic                       m_rx_axis_tuser,
    input  logic                       m_rx_axis_tready
);

    logic hold_valid;   // m_rx_axis_tdata holds a popped byte
    logic frame_bad;    // Any error flag in the head status
    logic beat;

    assign frame_bad = rd_entry.word.status.crc_bad | rd_entry.word.status.phy_err |
                       rd_entry.word.status.runt | rd_entry.word.status.overflow;

    // Offer the held byte only once its successor is visible
    assign m_rx_axis_tvalid = hold_valid && !empty;
    assign m_rx_axis_tlast  = m_rx_axis_tvalid && rd_entry.kind;   // Successor is status
    assign m_rx_axis_tuser  = m_rx_axis_tlast && frame_bad;
    assign beat             = m_rx_axis_tvalid && m_rx_axis_tready;

    // Fill an empty holder, or consume the successor along with the beat
    assign rd_en = !empty && (!hold_valid || beat);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            hold_valid <= 1'b0;
        end else if (rd_en) begin
            hold_valid <= !rd_entry.kind;   // Status closes the frame, or is discarded
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en && !rd_entry.kind)
            m_rx_axis_tdata <= rd_entry.word.data;
    end

endmodule

//--- verilog/rx_mac_top.sv
`timescale 1ns/1ps
`include "rx_mac_consts.svh"

module rx_mac_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [`RX_DATA_WIDTH-1:0] rx_data,
    input  logic                      rx_dv,
    input  logic                      rx_er,
    output logic [`RX_DATA_WIDTH-1:0] m_rx_axis_tdata,
    output logic                      m_rx_axis_tvalid,
    output logic                      m_rx_axis_tlast,
    output logic                      m_rx_axis_tuser,
    input  logic                      m_rx_axis_tready
);

    // Synchronizer to checker
    logic                       byte_valid;
    logic [`RX_DATA_WIDTH-1:0]  byte_data;
    logic                       byte_err;
    logic                       frame_start;
    logic                       frame_end;
    // Checker to queue
    logic                       wr_en;
    rx_queue_pkg::queue_entry_t wr_entry;
    logic                       almost_full;
    // Queue to stream formatter
    logic                       rd_en;
    rx_queue_pkg::queue_entry_t rd_entry;
    logic                       empty;

    rx_frame_sync rx_frame_sync_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .rx_data     (rx_data),
        .rx_dv       (rx_dv),
        .rx_er       (rx_er),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_err    (byte_err),
        .frame_start (frame_start),
        .frame_end   (frame_end)
    );

    rx_fcs_check rx_fcs_check_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_err    (byte_err),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .almost_full (almost_full),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry)
    );

    rx_entry_queue #(
        .DEPTH (`RX_QUEUE_DEPTH)
    ) rx_entry_queue_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry),
        .rd_en       (rd_en),
        .rd_entry    (rd_entry),
        .empty       (empty),
        .almost_full (almost_full)
    );

    rx_stream_out rx_stream_out_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .rd_entry         (rd_entry),
        .empty            (empty),
        .rd_en            (rd_en),
        .m_rx_axis_tdata  (m_rx_axis_tdata),
        .m_rx_axis_tvalid (m_rx_axis_tvalid),
        .m_rx_axis_tlast  (m_rx_axis_tlast),
        .m_rx_axis_tuser  (m_rx_axis_tuser),
        .m_rx_axis_tready (m_rx_axis_tready)
    );

endmodule

//--- verification/tb_rx_mac.sv
`timescale 1ns/1ps
`include "rx_mac_consts.svh"

module tb_rx_mac;

    localparam int clk_period   = 100;
    localparam int idle_cycles  = 12;   // Inter-frame gap on the PHY side
    localparam int drain_cycles = 30;   // Quiet time to catch extra beats
    localparam int num_rows     = 10;
    localparam int ready_always = 0;
    localparam int ready_random = 1;
    localparam int ready_stall  = 2;

    logic                      clk;
    logic                      reset_n;
    logic [`RX_DATA_WIDTH-1:0] rx_data;
    logic                      rx_dv;
    logic                      rx_er;
    logic [`RX_DATA_WIDTH-1:0] m_rx_axis_tdata;
    logic                      m_rx_axis_tvalid;
    logic                      m_rx_axis_tlast;
    logic                      m_rx_axis_tuser;
    logic                      m_rx_axis_tready;

    // Stimulus table with one entry per test
    int row_len [num_rows];       // Frame length with FCS
    int row_pre [num_rows];       // Preamble bytes
    int row_sfd [num_rows];
    int row_corrupt [num_rows];   // Flip one FCS bit
    int row_err [num_rows];       // rx_er byte position or -1 for none
    int row_mode [num_rows];
    int row_stall [num_rows];     // Ready low cycles in stall mode
    int row_exp_cnt [num_rows];
    int row_exp_user [num_rows];
    int rows_loaded;

    logic [7:0] frame_bytes [$];   // Bytes sent after the SFD
    logic [7:0] rx_bytes [$];      // Beats collected by the monitor
    int         frames_seen;
    logic       frame_user;        // tuser on the last tlast beat
    logic       user_early;        // tuser seen without tlast
    int         ready_mode;
    int         stall_left;
    int         error_count;
    int         pass_count;
    int         fail_count;
    int         budget_cycles;
    int         seed_ret;

    rx_mac_top rx_mac_top_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .rx_data          (rx_data),
        .rx_dv            (rx_dv),
        .rx_er            (rx_er),
        .m_rx_axis_tdata  (m_rx_axis_tdata),
        .m_rx_axis_tvalid (m_rx_axis_tvalid),
        .m_rx_axis_tlast  (m_rx_axis_tlast),
        .m_rx_axis_tuser  (m_rx_axis_tuser),
        .m_rx_axis_tready (m_rx_axis_tready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic add_row(input int len, input int pre, input int sfd, input int corrupt,
                           input int err, input int mode, input int stall,
                           input int exp_cnt, input int exp_user);
        row_len[rows_loaded]      = len;
        row_pre[rows_loaded]      = pre;
        row_sfd[rows_loaded]      = sfd;
        row_corrupt[rows_loaded]  = corrupt;
        row_err[rows_loaded]      = err;
        row_mode[rows_loaded]     = mode;
        row_stall[rows_loaded]    = stall;
        row_exp_cnt[rows_loaded]  = exp_cnt;
        row_exp_user[rows_loaded] = exp_user;
        rows_loaded++;
    endtask

    task automatic load_table();
        rows_loaded = 0;
        add_row(64, 7, 1, 0, -1, ready_always, 0, 60, 0);    // Minimum good frame
        add_row(200, 7, 1, 0, -1, ready_always, 0, 196, 0);
        add_row(80, 7, 1, 1, -1, ready_always, 0, 76, 1);    // Bad FCS
        add_row(90, 7, 1, 0, 20, ready_always, 0, 86, 1);    // rx_er mid-frame
        add_row(40, 7, 1, 0, -1, ready_always, 0, 36, 1);    // Runt
        add_row(150, 7, 1, 0, -1, ready_random, 0, 146, 0);
        // Queue keeps DEPTH-1 bytes and the output holder one more
        add_row(100, 7, 1, 0, -1, ready_stall, 150, `RX_QUEUE_DEPTH, 1);
        add_row(64, 7, 0, 0, -1, ready_always, 0, 0, 0);     // No SFD after preamble
        add_row(0, 5, 0, 0, -1, ready_always, 0, 0, 0);      // Preamble burst only
        add_row(64, 3, 1, 0, -1, ready_always, 0, 60, 0);    // Recovery after junk
    endtask

    // Reference reflected CRC-32 with the LSB of each byte first
    function automatic logic [31:0] crc_of(input int n);
        logic [31:0] crc;
        logic [7:0]  cur;
        crc = 32'hFFFF_FFFF;
        for (int k = 0; k < n; k++) begin
            cur = frame_bytes[k];
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ cur[b])
                    crc = (crc >> 1) ^ 32'hEDB8_8320;
                else
                    crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    // One PHY cycle with ready set by the current mode
    task automatic drive_cycle(input logic [7:0] data, input logic dv, input logic er);
        @(negedge clk);
        rx_data = data;
        rx_dv   = dv;
        rx_er   = er;
        case (ready_mode)
            ready_random: m_rx_axis_tready = ($urandom % 16) != 0;   // Mostly high
            ready_stall: begin
                m_rx_axis_tready = (stall_left == 0);
                if (stall_left > 0)
                    stall_left--;
            end
            default: m_rx_axis_tready = 1'b1;
        endcase
    endtask

    // Beats are sampled a quarter period after the inputs change
    initial begin
        frames_seen = 0;
        frame_user  = 1'b0;
        user_early  = 1'b0;
        forever begin
            @(negedge clk);
            #(clk_period / 4);
            if (m_rx_axis_tvalid === 1'b1 && m_rx_axis_tready === 1'b1) begin
                rx_bytes.push_back(m_rx_axis_tdata);
                if (m_rx_axis_tuser && !m_rx_axis_tlast)
                    user_early = 1'b1;
                if (m_rx_axis_tlast) begin
                    frame_user = m_rx_axis_tuser;
                    frames_seen++;
                end
            end
        end
    end

    task automatic run_row(input int r);
        int          len;
        int          frames_before;
        int          errors_before;
        int          waited;
        int          limit;
        int          got;
        int          exp_cnt;
        logic [7:0]  b;
        logic [31:0] fcs;
        len           = row_len[r];
        exp_cnt       = row_exp_cnt[r];
        frames_before = frames_seen;
        errors_before = error_count;
        frame_bytes.delete();
        rx_bytes.delete();
        user_early = 1'b0;
        if (len >= 4) begin
            for (int i = 0; i < len - 4; i++) begin
                b = $urandom;
                frame_bytes.push_back(b);
            end
            fcs = ~crc_of(len - 4);
            frame_bytes.push_back(fcs[7:0]);   // FCS goes out low byte first
            frame_bytes.push_back(fcs[15:8]);
            frame_bytes.push_back(fcs[23:16]);
            frame_bytes.push_back(fcs[31:24]);
            if (row_corrupt[r] != 0)
                frame_bytes[len - 1] = frame_bytes[len - 1] ^ 8'h10;
        end
        if (row_sfd[r] == 0) begin
            foreach (frame_bytes[i]) begin
                if (frame_bytes[i] == `ETH_PREAMBLE || frame_bytes[i] == `ETH_SFD)
                    frame_bytes[i] = 8'h54;   // Keep the FSM from locking on
            end
        end
        ready_mode = row_mode[r];
        stall_left = row_stall[r];
        for (int i = 0; i < row_pre[r]; i++)
            drive_cycle(`ETH_PREAMBLE, 1'b1, 1'b0);
        if (row_sfd[r] != 0)
            drive_cycle(`ETH_SFD, 1'b1, 1'b0);
        for (int i = 0; i < len; i++)
            drive_cycle(frame_bytes[i], 1'b1, i == row_err[r]);
        repeat (idle_cycles) drive_cycle(8'h00, 1'b0, 1'b0);
        limit  = 4 * len + row_stall[r] + 100;
        waited = 0;
        if (exp_cnt > 0) begin
            while (frames_seen == frames_before && waited < limit) begin
                drive_cycle(8'h00, 1'b0, 1'b0);
                waited++;
            end
        end
        repeat (drain_cycles) drive_cycle(8'h00, 1'b0, 1'b0);
        got = rx_bytes.size();
        if (exp_cnt == 0) begin
            if (got != 0 || frames_seen != frames_before) begin
                $display("Test %0d: %0d bytes arrived for a frame that should be dropped",
                         r, got);
                error_count++;
            end
        end else if (frames_seen == frames_before) begin
            $display("Test %0d: no frame arrived within %0d cycles", r, limit);
            error_count++;
        end else begin
            if (frames_seen - frames_before > 1) begin
                $display("Test %0d: an extra frame arrived", r);
                error_count++;
            end
            for (int i = 0; i < got && i < exp_cnt; i++) begin
                if (rx_bytes[i] !== frame_bytes[i]) begin
                    $display("MISMATCH m_rx_axis_tdata[%0d]: got %h, expected %h",
                             i, rx_bytes[i], frame_bytes[i]);
                    error_count++;
                end
            end
            if (got != exp_cnt) begin
                $display("MISMATCH m_rx_axis_tlast beat index: got %h, expected %h",
                         got - 1, exp_cnt - 1);
                error_count++;
            end
            if (frame_user !== row_exp_user[r][0]) begin
                $display("MISMATCH m_rx_axis_tuser: got %h, expected %h",
                         frame_user, row_exp_user[r][0]);
                error_count++;
            end
            if (user_early) begin
                $display("Test %0d: tuser was set on a beat without tlast", r);
                error_count++;
            end
        end
        if (error_count == errors_before) begin
            pass_count++;
            $display("Test %0d: len %0d, %0d bytes out, pass", r, len, got);
        end else begin
            fail_count++;
            $display("Test %0d: len %0d, %0d bytes out, fail", r, len, got);
        end
    endtask

    // Watchdog counts from the release of reset
    initial begin
        wait (reset_n === 1'b1);
        repeat (budget_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", budget_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset_n          = 1'b0;
        rx_data          = '0;
        rx_dv            = 1'b0;
        rx_er            = 1'b0;
        m_rx_axis_tready = 1'b1;
        ready_mode       = ready_always;
        stall_left       = 0;
        error_count      = 0;
        pass_count       = 0;
        fail_count       = 0;
        budget_cycles    = 0;
        seed_ret         = $urandom(6691);
        load_table();
        budget_cycles = 10;   // Small margin
        for (int r = 0; r < num_rows; r++) begin
            budget_cycles += 4 * (row_len[r] + row_pre[r] + 1 + idle_cycles +
                                  row_stall[r] + drain_cycles);
        end
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        for (int r = 0; r < num_rows; r++)
            run_row(r);
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/eth_frame_pkg.sv
verilog/rx_queue_pkg.sv
verilog/rx_frame_sync.sv
verilog/crc32_byte.sv
verilog/rx_fcs_check.sv
verilog/rx_entry_queue.sv
verilog/rx_stream_out.sv
verilog/rx_mac_top.sv
verification/tb_rx_mac.sv
